// ==== hw/mmio_params.svh ====
`ifndef MMIO_PARAMS_SVH
`define MMIO_PARAMS_SVH

// Number of MMIO read tags the host may have outstanding at once
`define MMIO_MAX_RD_TAGS 64

// Payload width carried by a single TLP channel of the transmit vector
`define MMIO_TLP_CH_PAYLOAD_BITS 256

// A full AFU read response spans both transmit channels
`define MMIO_RSP_PAYLOAD_BITS (2 * `MMIO_TLP_CH_PAYLOAD_BITS)

`endif

// ==== hw/pcie_tlp_pkg.sv ====
`default_nettype none

`include "mmio_params.svh"

package pcie_tlp_pkg;

    // Combined fmt and type byte of the first header DW
    typedef enum logic [7:0] {
        MemRd32 = 8'h00,
        MemRd64 = 8'h20,
        MemWr32 = 8'h40,
        MemWr64 = 8'h60,
        CplD    = 8'h4a
    } t_fmttype;

    // Payload length in DW units
    typedef logic [9:0] t_tlp_length;

    // Completion byte count field
    typedef logic [11:0] t_tlp_byte_count;

    typedef logic [15:0] t_requester_id;

    // Tag as it sits on the wire, wider than the tags the MMIO path uses
    typedef logic [7:0] t_tlp_tag;

    typedef logic [63:0] t_tlp_addr;

    typedef logic [6:0] t_tlp_lower_addr;

    // Raw header slot of a channel, big enough for either header format
    typedef logic [127:0] t_tlp_hdr;

    typedef logic [`MMIO_TLP_CH_PAYLOAD_BITS-1:0] t_tlp_ch_payload;

    // Memory request header, padded out to four DW
    typedef struct packed {
        t_fmttype      fmttype;
        t_tlp_length   length;
        t_requester_id requester_id;
        t_tlp_tag      tag;
        logic [21:0]   rsvd;
        t_tlp_addr     addr;
    } t_tlp_req_hdr;

    // Completion header, padded out to four DW
    typedef struct packed {
        t_fmttype        fmttype;
        t_tlp_length     length;
        t_tlp_byte_count byte_count;
        t_requester_id   requester_id;
        t_tlp_tag        tag;
        t_tlp_lower_addr lower_addr;
        logic [66:0]     rsvd;
    } t_tlp_cpl_hdr;

    // One channel of the TX/RX TLP vector
    // Only a channel that carries sop has a meaningful hdr
    typedef struct packed {
        logic            valid;
        logic            sop;
        logic            eop;
        t_tlp_hdr        hdr;
        t_tlp_ch_payload payload;
    } t_tlp_ch;

endpackage

`default_nettype wire

// ==== hw/mmio_rsp_pkg.sv ====
`default_nettype none

`include "mmio_params.svh"

package mmio_rsp_pkg;

    // Tag index into the outstanding read table
    typedef logic [$clog2(`MMIO_MAX_RD_TAGS)-1:0] t_mmio_tag;

    // Read size in bytes, 4 up to 64
    typedef logic [6:0] t_mmio_byte_count;

    typedef logic [6:0] t_mmio_lower_addr;

    typedef logic [`MMIO_RSP_PAYLOAD_BITS-1:0] t_mmio_rsp_payload;

    // Details of a host read that the completion has to echo back
    typedef struct packed {
        t_mmio_tag                   tag;
        pcie_tlp_pkg::t_requester_id requester_id;
        t_mmio_lower_addr            lower_addr;
        t_mmio_byte_count            byte_count;
    } t_mmio_host_req;

    // Read request presented to the AFU
    typedef struct packed {
        t_mmio_tag               tag;
        pcie_tlp_pkg::t_tlp_addr address;
        t_mmio_byte_count        byte_count;
    } t_mmio_afu_req;

    // Read data returned by the AFU
    // Bytes above the requested size are ignored by the host
    typedef struct packed {
        t_mmio_tag         tag;
        t_mmio_rsp_payload payload;
    } t_mmio_afu_rsp;

endpackage

`default_nettype wire

// ==== hw/mmio_rd_req_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module mmio_rd_req_decode
(
    input  logic                        clk,
    input  logic                        reset_n,

    // Incoming request headers from the host are always accepted
    input  logic                        rx_valid,
    input  pcie_tlp_pkg::t_tlp_req_hdr  rx_hdr,

    // Request details kept for the completion generator
    output logic                        host_req_valid,
    output mmio_rsp_pkg::t_mmio_host_req host_req,

    // Read strobe and request toward the AFU
    output logic                        afu_req_valid,
    output mmio_rsp_pkg::t_mmio_afu_req afu_req
);

    logic                           is_mem_rd;
    mmio_rsp_pkg::t_mmio_tag        rx_tag;
    mmio_rsp_pkg::t_mmio_byte_count rx_byte_count;
    mmio_rsp_pkg::t_mmio_lower_addr rx_lower_addr;

    // Both address widths of a memory read are handled the same way
    // Writes and every other type fall through and are dropped here
    assign is_mem_rd = rx_valid &&
                       ((rx_hdr.fmttype == pcie_tlp_pkg::MemRd32) ||
                        (rx_hdr.fmttype == pcie_tlp_pkg::MemRd64));

    // The MMIO path only tracks as many tags as the read table holds
    assign rx_tag = mmio_rsp_pkg::t_mmio_tag'(rx_hdr.tag);

    // Length is in DW, so the byte count is the length shifted by two
    // A 16 DW read gives 64, which still fits the 7-bit count
    assign rx_byte_count = {rx_hdr.length[4:0], 2'b00};

    // The completion reports the low address bits of the request
    assign rx_lower_addr = rx_hdr.addr[6:0];

    // Each accepted read gives a one-cycle strobe on both outputs
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            host_req_valid <= 1'b0;
            afu_req_valid  <= 1'b0;
        end
        else
        begin
            host_req_valid <= is_mem_rd;
            afu_req_valid  <= is_mem_rd;
        end
    end

    // Both records load in the same cycle and only for a read
    always_ff @(posedge clk)
    begin
        if (is_mem_rd)
        begin
            host_req.tag          <= rx_tag;
            host_req.requester_id <= rx_hdr.requester_id;
            host_req.lower_addr   <= rx_lower_addr;
            host_req.byte_count   <= rx_byte_count;

            afu_req.tag           <= rx_tag;
            afu_req.address       <= rx_hdr.addr;
            afu_req.byte_count    <= rx_byte_count;
        end
    end

endmodule

`default_nettype wire

// ==== hw/mmio_tag_meta_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module mmio_tag_meta_ram
#(
    parameter int N_ENTRIES   = 64,
    parameter int N_DATA_BITS = 32
)
(
    input  logic                         clk,

    input  logic                         wen,
    input  logic [$clog2(N_ENTRIES)-1:0] waddr,
    input  logic [N_DATA_BITS-1:0]       wdata,

    input  logic [$clog2(N_ENTRIES)-1:0] raddr,
    output logic [N_DATA_BITS-1:0]       rdata
);

    // One record per tag, small enough to map onto LUT RAM
    logic [N_DATA_BITS-1:0] mem [N_ENTRIES];

    always_ff @(posedge clk)
    begin
        if (wen)
        begin
            mem[waddr] <= wdata;
        end
    end

    // Read is combinational so the record is ready in the same cycle
    // as the AFU response that names the tag
    assign rdata = mem[raddr];

endmodule

`default_nettype wire

// ==== hw/mmio_rsp_fifo2.sv ====
`timescale 1ns/1ps
`default_nettype none

module mmio_rsp_fifo2
#(
    parameter int N_DATA_BITS = 32
)
(
    input  logic                   clk,
    input  logic                   reset_n,

    // On the enqueue side enq_en must only be raised while not_full
    input  logic                   enq_en,
    input  logic [N_DATA_BITS-1:0] enq_data,
    output logic                   not_full,

    // On the dequeue side deq_en must only be raised while not_empty
    input  logic                   deq_en,
    output logic [N_DATA_BITS-1:0] first,
    output logic                   not_empty
);

    // Entry 0 is always the head and entry 1 is only used when both are full
    logic [N_DATA_BITS-1:0] data0;
    logic [N_DATA_BITS-1:0] data1;
    logic [1:0]             count;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            count <= 2'd0;
        end
        else
        begin
            case ({enq_en, deq_en})
                2'b10: count <= count + 2'd1;
                2'b01: count <= count - 2'd1;
                default: count <= count;
            endcase
        end
    end

    // Entries shift toward the head as the FIFO drains
    always_ff @(posedge clk)
    begin
        if (deq_en)
        begin
            // The second entry moves up, or a new entry goes straight to the head
            data0 <= (count == 2'd2) ? data1 : enq_data;
            data1 <= enq_data;
        end
        else if (enq_en)
        begin
            if (count == 2'd0)
            begin
                data0 <= enq_data;
            end
            else
            begin
                data1 <= enq_data;
            end
        end
    end

    assign first     = data0;
    assign not_empty = (count != 2'd0);
    assign not_full  = (count != 2'd2);

endmodule

`default_nettype wire

// ==== hw/mmio_cpl_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mmio_params.svh"

module mmio_cpl_gen
(
    input  logic                          clk,
    input  logic                          reset_n,

    // Decoded host reads, always accepted
    input  logic                          host_req_valid,
    input  mmio_rsp_pkg::t_mmio_host_req  host_req,

    // Read data from the AFU
    input  logic                          afu_rsp_valid,
    input  mmio_rsp_pkg::t_mmio_afu_rsp   afu_rsp,
    output logic                          afu_rsp_ready,

    // Completion TLP vector toward the host
    output logic                          tx_valid,
    output pcie_tlp_pkg::t_tlp_ch [1:0]   tx_ch,
    output logic                          tx_last,
    input  logic                          tx_ready,

    output logic                          error
);

    // A buffered response travels with the request record it answers
    typedef struct packed {
        mmio_rsp_pkg::t_mmio_afu_rsp  rsp;
        mmio_rsp_pkg::t_mmio_host_req meta;
    } t_rsp_entry;

    logic                         host_req_valid_q;
    mmio_rsp_pkg::t_mmio_host_req host_req_q;
    mmio_rsp_pkg::t_mmio_host_req afu_rsp_meta;
    logic                         afu_rsp_accept;
    t_rsp_entry                   fifo_in;
    t_rsp_entry                   fifo_head;
    logic                         fifo_deq;
    logic                         fifo_not_empty;
    logic                         tx_free;
    pcie_tlp_pkg::t_tlp_cpl_hdr   cpl_hdr;
    logic                         dual_ch;
    pcie_tlp_pkg::t_tlp_ch [1:0]  tx_ch_next;
    logic [`MMIO_MAX_RD_TAGS-1:0] tag_active;

    // Stage the request one cycle before it is written to the table
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            host_req_valid_q <= 1'b0;
        end
        else
        begin
            host_req_valid_q <= host_req_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        host_req_q <= host_req;
    end

    // Request details indexed by tag and looked up by the response tag
    mmio_tag_meta_ram
    #(
        .N_ENTRIES   (`MMIO_MAX_RD_TAGS),
        .N_DATA_BITS ($bits(mmio_rsp_pkg::t_mmio_host_req))
    )
    u_meta_ram
    (
        .clk   (clk),
        .wen   (host_req_valid_q),
        .waddr (host_req_q.tag),
        .wdata (host_req_q),
        .raddr (afu_rsp.tag),
        .rdata (afu_rsp_meta)
    );

    assign afu_rsp_accept = afu_rsp_valid && afu_rsp_ready;

    assign fifo_in.rsp  = afu_rsp;
    assign fifo_in.meta = afu_rsp_meta;

    // The FIFO absorbs responses while the host holds off the TX port
    mmio_rsp_fifo2
    #(
        .N_DATA_BITS ($bits(t_rsp_entry))
    )
    u_rsp_fifo
    (
        .clk       (clk),
        .reset_n   (reset_n),
        .enq_en    (afu_rsp_accept),
        .enq_data  (fifo_in),
        .not_full  (afu_rsp_ready),
        .deq_en    (fifo_deq),
        .first     (fifo_head),
        .not_empty (fifo_not_empty)
    );

    // The output register can take a new beat when empty or draining
    assign tx_free  = tx_ready || !tx_valid;
    assign fifo_deq = fifo_not_empty && tx_free;

    // Completion header built from the recorded request
    always_comb
    begin
        cpl_hdr              = '0;
        cpl_hdr.fmttype      = pcie_tlp_pkg::CplD;
        cpl_hdr.length       = pcie_tlp_pkg::t_tlp_length'(fifo_head.meta.byte_count[6:2]);
        cpl_hdr.byte_count   = pcie_tlp_pkg::t_tlp_byte_count'(fifo_head.meta.byte_count);
        cpl_hdr.requester_id = fifo_head.meta.requester_id;
        cpl_hdr.tag          = pcie_tlp_pkg::t_tlp_tag'(fifo_head.rsp.tag);
        cpl_hdr.lower_addr   = fifo_head.meta.lower_addr;
    end

    // More than one channel's worth of data needs the second channel
    assign dual_ch = (fifo_head.meta.byte_count > 7'd32);

    always_comb
    begin
        tx_ch_next = '0;

        tx_ch_next[0].valid = 1'b1;
        tx_ch_next[0].sop   = 1'b1;
        tx_ch_next[0].eop   = !dual_ch;
        tx_ch_next[0].hdr   = cpl_hdr;

        // Second channel is data only, continuing the same packet
        tx_ch_next[1].valid = dual_ch;
        tx_ch_next[1].eop   = dual_ch;

        {tx_ch_next[1].payload, tx_ch_next[0].payload} = fifo_head.rsp.payload;
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            tx_valid <= 1'b0;
        end
        else if (tx_free)
        begin
            tx_valid <= fifo_not_empty;
        end
    end

    // Data only changes when a new completion is taken from the FIFO
    always_ff @(posedge clk)
    begin
        if (fifo_deq)
        begin
            tx_ch   <= tx_ch_next;
            tx_last <= tx_ch_next[0].eop || tx_ch_next[1].eop;
        end
    end

    // Outstanding tag tracking
    // A clear and a set in the same cycle leave the set in place
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            tag_active <= '0;
            error      <= 1'b0;
        end
        else
        begin
            if (afu_rsp_accept)
            begin
                tag_active[afu_rsp.tag] <= 1'b0;
            end

            if (host_req_valid)
            begin
                tag_active[host_req.tag] <= 1'b1;
            end

            // Error stays up until the next reset
            if ((host_req_valid && tag_active[host_req.tag]) ||
                (afu_rsp_accept && !tag_active[afu_rsp.tag]))
            begin
                error <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/mmio_rd_subsys.sv ====
`timescale 1ns/1ps
`default_nettype none

module mmio_rd_subsys
(
    input  logic                          clk,
    input  logic                          reset_n,

    // Host request headers, no back-pressure
    input  logic                          rx_valid,
    input  pcie_tlp_pkg::t_tlp_req_hdr    rx_hdr,

    // Read requests toward the AFU
    output logic                          afu_req_valid,
    output mmio_rsp_pkg::t_mmio_afu_req   afu_req,

    // Read responses from the AFU
    input  logic                          afu_rsp_valid,
    input  mmio_rsp_pkg::t_mmio_afu_rsp   afu_rsp,
    output logic                          afu_rsp_ready,

    // Completion stream toward the host
    output logic                          tx_valid,
    output pcie_tlp_pkg::t_tlp_ch [1:0]   tx_ch,
    output logic                          tx_last,
    input  logic                          tx_ready,

    // Sticky tag tracking error
    output logic                          error
);

    // Decoder to completion generator
    logic                         host_req_valid;
    mmio_rsp_pkg::t_mmio_host_req host_req;

    mmio_rd_req_decode u_decode
    (
        .clk            (clk),
        .reset_n        (reset_n),
        .rx_valid       (rx_valid),
        .rx_hdr         (rx_hdr),
        .host_req_valid (host_req_valid),
        .host_req       (host_req),
        .afu_req_valid  (afu_req_valid),
        .afu_req        (afu_req)
    );

    mmio_cpl_gen u_cpl_gen
    (
        .clk            (clk),
        .reset_n        (reset_n),
        .host_req_valid (host_req_valid),
        .host_req       (host_req),
        .afu_rsp_valid  (afu_rsp_valid),
        .afu_rsp        (afu_rsp),
        .afu_rsp_ready  (afu_rsp_ready),
        .tx_valid       (tx_valid),
        .tx_ch          (tx_ch),
        .tx_last        (tx_last),
        .tx_ready       (tx_ready),
        .error          (error)
    );

endmodule

`default_nettype wire

// ==== sim/tb_mmio_rd_subsys.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mmio_params.svh"

module tb_mmio_rd_subsys;

    localparam int CH_BITS    = `MMIO_TLP_CH_PAYLOAD_BITS;
    localparam int RSP_BITS   = `MMIO_RSP_PAYLOAD_BITS;
    localparam int WAIT_LIMIT = 50;

    // What a test remembers about each read it sent to the DUT
    typedef struct packed {
        mmio_rsp_pkg::t_mmio_tag     tag;
        pcie_tlp_pkg::t_tlp_addr     addr;
        pcie_tlp_pkg::t_requester_id req_id;
        logic [4:0]                  len_dw;
    } t_req_rec;

    logic                        clk;
    logic                        reset_n;
    logic                        rx_valid;
    pcie_tlp_pkg::t_tlp_req_hdr  rx_hdr;
    logic                        afu_req_valid;
    mmio_rsp_pkg::t_mmio_afu_req afu_req;
    logic                        afu_rsp_valid;
    mmio_rsp_pkg::t_mmio_afu_rsp afu_rsp;
    logic                        afu_rsp_ready;
    logic                        tx_valid;
    pcie_tlp_pkg::t_tlp_ch [1:0] tx_ch;
    logic                        tx_last;
    logic                        tx_ready;
    logic                        error;

    logic [31:0]                  lfsr_state;
    // Every tag that has appeared in a request header
    logic [`MMIO_MAX_RD_TAGS-1:0] tag_used;

    mmio_rd_subsys uut
    (
        .clk           (clk),
        .reset_n       (reset_n),
        .rx_valid      (rx_valid),
        .rx_hdr        (rx_hdr),
        .afu_req_valid (afu_req_valid),
        .afu_req       (afu_req),
        .afu_rsp_valid (afu_rsp_valid),
        .afu_rsp       (afu_rsp),
        .afu_rsp_ready (afu_rsp_ready),
        .tx_valid      (tx_valid),
        .tx_ch         (tx_ch),
        .tx_last       (tx_last),
        .tx_ready      (tx_ready),
        .error         (error)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Taps 32, 22, 2 and 1 give a maximal length sequence
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    // One LFSR step for every bit taken
    task automatic rand_bits(input int n_bits, output logic [RSP_BITS-1:0] value);
        value = '0;
        for (int i = 0; i < n_bits; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            value[i]   = lfsr_state[0];
        end
    endtask

    // Inputs change and outputs are read 1 ns after the rising edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic abort_run();
        $display("Done: errors found");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic timeout_fail(input string what);
        $display("Timeout: %s", what);
        abort_run();
    endtask

    task automatic check(input string test_name, input string field,
                         input logic [RSP_BITS-1:0] expected,
                         input logic [RSP_BITS-1:0] actual);
        if (actual !== expected)
        begin
            $display("[FAIL] %s: %s expected %0h actual %0h",
                     test_name, field, expected, actual);
            abort_run();
        end
    endtask

    // Random tag, address and requester ID for a read of the given size
    task automatic new_request(input logic [4:0] len_dw, output t_req_rec rec);
        logic [RSP_BITS-1:0] r;
        rand_bits(6, r);
        rec.tag = r[5:0];
        rand_bits(64, r);
        rec.addr = r[63:0];
        rand_bits(16, r);
        rec.req_id = r[15:0];
        rec.len_dw = len_dw;
    endtask

    // Pulses rx_valid for one cycle with a header built from the record
    task automatic send_hdr(input t_req_rec rec, input pcie_tlp_pkg::t_fmttype fmt);
        pcie_tlp_pkg::t_tlp_req_hdr hdr;
        hdr              = '0;
        hdr.fmttype      = fmt;
        hdr.length       = {5'd0, rec.len_dw};
        hdr.requester_id = rec.req_id;
        hdr.tag          = {2'b00, rec.tag};
        hdr.addr         = rec.addr;
        tag_used[rec.tag] = 1'b1;
        rx_hdr   = hdr;
        rx_valid = 1'b1;
        step();
        rx_valid = 1'b0;
    endtask

    // Sends a MemRd and checks the read strobe that the AFU sees
    task automatic send_read(input string test_name, input t_req_rec rec,
                             input pcie_tlp_pkg::t_fmttype fmt);
        int cycles;
        send_hdr(rec, fmt);
        cycles = 0;
        while (!afu_req_valid)
        begin
            if (cycles == WAIT_LIMIT)
            begin
                timeout_fail("afu_req_valid never rose after a memory read header");
            end
            step();
            cycles++;
        end
        check(test_name, "afu_req.tag", rec.tag, afu_req.tag);
        check(test_name, "afu_req.address", rec.addr, afu_req.address);
        check(test_name, "afu_req.byte_count", int'(rec.len_dw) * 4, afu_req.byte_count);
    endtask

    // AFU model that holds the response valid until the DUT takes it
    task automatic afu_respond(input mmio_rsp_pkg::t_mmio_tag tag,
                               input logic [RSP_BITS-1:0] payload);
        int   cycles;
        logic accepted;
        afu_rsp.tag     = tag;
        afu_rsp.payload = payload;
        afu_rsp_valid   = 1'b1;
        accepted        = 1'b0;
        cycles          = 0;
        while (!accepted)
        begin
            if (cycles == WAIT_LIMIT)
            begin
                timeout_fail("afu_rsp_ready stayed low and the AFU response was not taken");
            end
            // Ready comes from a register, so it holds until the next edge
            accepted = afu_rsp_ready;
            step();
            cycles++;
        end
        afu_rsp_valid = 1'b0;
    endtask

    // Waits for a completion, checks it against the request, then takes it
    task automatic check_completion(input string test_name, input t_req_rec rec,
                                    input logic [RSP_BITS-1:0] payload);
        pcie_tlp_pkg::t_tlp_cpl_hdr hdr;
        int                         cycles;
        int                         bytes;
        logic                       dual;
        cycles = 0;
        while (!tx_valid)
        begin
            if (cycles == WAIT_LIMIT)
            begin
                timeout_fail("tx_valid never rose for an expected completion");
            end
            step();
            cycles++;
        end
        hdr   = pcie_tlp_pkg::t_tlp_cpl_hdr'(tx_ch[0].hdr);
        bytes = int'(rec.len_dw) * 4;
        dual  = (bytes > 32);
        check(test_name, "fmttype", pcie_tlp_pkg::CplD, hdr.fmttype);
        check(test_name, "length", rec.len_dw, hdr.length);
        check(test_name, "byte_count", bytes, hdr.byte_count);
        check(test_name, "requester_id", rec.req_id, hdr.requester_id);
        check(test_name, "tag", rec.tag, hdr.tag);
        check(test_name, "lower_addr", rec.addr[6:0], hdr.lower_addr);
        check(test_name, "ch0.valid", 1'b1, tx_ch[0].valid);
        check(test_name, "ch0.sop", 1'b1, tx_ch[0].sop);
        // The packet ends on channel 1 only when the data spills over
        check(test_name, "ch0.eop", !dual, tx_ch[0].eop);
        check(test_name, "ch1.valid", dual, tx_ch[1].valid);
        check(test_name, "ch1.eop", dual, tx_ch[1].eop);
        check(test_name, "tx_last", 1'b1, tx_last);
        check(test_name, "ch0.payload", payload[CH_BITS-1:0], tx_ch[0].payload);
        if (dual)
        begin
            check(test_name, "ch1.sop", 1'b0, tx_ch[1].sop);
            check(test_name, "ch1.payload", payload[RSP_BITS-1:CH_BITS], tx_ch[1].payload);
        end
        step();
    endtask

    task automatic test_decode();
        t_req_rec            rd_rec;
        t_req_rec            wr_rec;
        logic [RSP_BITS-1:0] r;
        logic [RSP_BITS-1:0] payload;
        rand_bits(4, r);
        new_request(5'(r[3:0]) + 5'd1, rd_rec);
        send_read("decode", rd_rec, pcie_tlp_pkg::MemRd64);
        step();
        // A write must be dropped without a strobe toward the AFU
        rand_bits(4, r);
        new_request(5'(r[3:0]) + 5'd1, wr_rec);
        send_hdr(wr_rec, pcie_tlp_pkg::MemWr32);
        for (int i = 0; i < 4; i++)
        begin
            check("decode", "afu_req_valid after MemWr", 1'b0, afu_req_valid);
            step();
        end
        // Close the read so its tag does not stay active
        rand_bits(RSP_BITS, payload);
        afu_respond(rd_rec.tag, payload);
        check_completion("decode", rd_rec, payload);
        check("decode", "error", 1'b0, error);
    endtask

    task automatic test_single_channel();
        t_req_rec            rec;
        logic [RSP_BITS-1:0] r;
        logic [RSP_BITS-1:0] payload;
        rand_bits(3, r);
        new_request(5'(r[2:0]) + 5'd1, rec);
        rand_bits(RSP_BITS, payload);
        send_read("single_channel", rec, pcie_tlp_pkg::MemRd32);
        // The record is written two cycles after the header arrives
        step();
        step();
        afu_respond(rec.tag, payload);
        check_completion("single_channel", rec, payload);
        check("single_channel", "error", 1'b0, error);
    endtask

    task automatic test_dual_channel();
        t_req_rec            rec;
        logic [RSP_BITS-1:0] payload;
        new_request(5'd16, rec);
        rand_bits(RSP_BITS, payload);
        send_read("dual_channel", rec, pcie_tlp_pkg::MemRd64);
        step();
        step();
        afu_respond(rec.tag, payload);
        check_completion("dual_channel", rec, payload);
        check("dual_channel", "error", 1'b0, error);
    endtask

    task automatic test_backpressure();
        t_req_rec            recs [3];
        logic [RSP_BITS-1:0] payloads [3];
        logic [RSP_BITS-1:0] r;
        int                  cycles;
        tx_ready = 1'b0;
        // Three outstanding reads need three different tags
        for (int i = 0; i < 3; i++)
        begin
            rand_bits(4, r);
            new_request(5'(r[3:0]) + 5'd1, recs[i]);
            if (i > 0)
            begin
                recs[i].tag = recs[0].tag + 6'(i);
            end
            rand_bits(RSP_BITS, payloads[i]);
            send_read("backpressure", recs[i], pcie_tlp_pkg::MemRd64);
        end
        step();
        step();
        for (int i = 0; i < 3; i++)
        begin
            afu_respond(recs[i].tag, payloads[i]);
        end
        // One completion sits in the TX register and two wait in the FIFO
        cycles = 0;
        while (afu_rsp_ready)
        begin
            if (cycles == WAIT_LIMIT)
            begin
                timeout_fail("afu_rsp_ready did not drop while tx_ready was held low");
            end
            step();
            cycles++;
        end
        check("backpressure", "tx_valid while held", 1'b1, tx_valid);
        tx_ready = 1'b1;
        for (int i = 0; i < 3; i++)
        begin
            check_completion("backpressure", recs[i], payloads[i]);
        end
        // Nothing may follow the third completion
        for (int i = 0; i < 4; i++)
        begin
            check("backpressure", "tx_valid after drain", 1'b0, tx_valid);
            step();
        end
        check("backpressure", "afu_rsp_ready after drain", 1'b1, afu_rsp_ready);
        check("backpressure", "error", 1'b0, error);
    endtask

    task automatic test_error_flag();
        logic [RSP_BITS-1:0]     r;
        logic [RSP_BITS-1:0]     payload;
        mmio_rsp_pkg::t_mmio_tag tag;
        int                      tries;
        check("error_flag", "error before stray response", 1'b0, error);
        rand_bits(6, r);
        tag   = r[5:0];
        tries = 0;
        while (tag_used[tag])
        begin
            if (tries == `MMIO_MAX_RD_TAGS)
            begin
                $display("Every tag has been used, so no stray response can be sent");
                abort_run();
            end
            tag = tag + 6'd1;
            tries++;
        end
        rand_bits(RSP_BITS, payload);
        afu_respond(tag, payload);
        check("error_flag", "error after stray response", 1'b1, error);
        // The flag is sticky until reset
        for (int i = 0; i < 6; i++)
        begin
            step();
            check("error_flag", "error held", 1'b1, error);
        end
    endtask

    initial
    begin
        lfsr_state    = 32'hf30d_4249;
        tag_used      = '0;
        reset_n       = 1'b0;
        rx_valid      = 1'b0;
        rx_hdr        = '0;
        afu_rsp_valid = 1'b0;
        afu_rsp       = '0;
        tx_ready      = 1'b1;
        repeat (8)
        begin
            step();
        end
        reset_n = 1'b1;
        check("reset", "tx_valid", 1'b0, tx_valid);
        check("reset", "afu_req_valid", 1'b0, afu_req_valid);
        check("reset", "host_req_valid", 1'b0, uut.host_req_valid);
        check("reset", "error", 1'b0, error);
        check("reset", "tag_active", '0, uut.u_cpl_gen.tag_active);
        step();
        test_decode();
        test_single_channel();
        test_dual_channel();
        test_backpressure();
        test_error_flag();
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+hw
hw/pcie_tlp_pkg.sv
hw/mmio_rsp_pkg.sv
hw/mmio_rd_req_decode.sv
hw/mmio_tag_meta_ram.sv
hw/mmio_rsp_fifo2.sv
hw/mmio_cpl_gen.sv
hw/mmio_rd_subsys.sv
sim/tb_mmio_rd_subsys.sv
